//--- hdl/rr_config.svh
`ifndef RR_CONFIG_SVH
`define RR_CONFIG_SVH

// issue width of the pipeline
`define RR_LANES 2

// architectural integer registers, r0 reads as zero
`define RR_NREGS 32

// data path width
`define RR_XLEN 32

// advances after leaving the latch during which
// a load result is still not forwardable
`define RR_LOAD_SHADOW 2

`endif

//--- hdl/isa_pkg.sv
`include "rr_config.svh"

package isa_pkg;

    localparam int REG_IDX_W = $clog2(`RR_NREGS);

    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`RR_XLEN-1:0]  word_t;
    typedef logic [11:0]          imm12_t;

    // instruction format, chosen by decode
    typedef enum logic {
        FMT_3R    = 1'b0,
        FMT_2RI12 = 1'b1
    } inst_fmt_e;

    // three register operands
    typedef struct packed {
        logic [16:0] opcode;
        reg_idx_t    rk;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } inst_r3_t;

    // two registers and a 12-bit immediate
    typedef struct packed {
        logic [9:0] opcode;
        imm12_t     imm12;
        reg_idx_t   rj;
        reg_idx_t   rd;
    } inst_ri12_t;

    // same word, two encodings
    typedef union packed {
        inst_r3_t   r3;
        inst_ri12_t ri12;
    } inst_word_u;

    typedef struct packed {
        inst_fmt_e  fmt;
        logic       is_load;
        logic [3:0] alu_op;
    } uop_t;

    function automatic word_t sext12(input imm12_t imm);
        return {{(`RR_XLEN-12){imm[11]}}, imm};
    endfunction

endpackage

//--- hdl/pipe_pkg.sv
`include "rr_config.svh"

package pipe_pkg;

    import isa_pkg::*;

    localparam int NLANES  = `RR_LANES;
    // one rj and one rk port per lane
    localparam int NRPORTS = 2 * `RR_LANES;
    localparam int NFWD    = 2;
    localparam int NWB     = 2;
    localparam int IDX_W   = $bits(reg_idx_t);
    localparam int XLEN    = $bits(word_t);

    // decode to register read
    typedef struct packed {
        logic       valid;
        word_t      pc;
        inst_word_u inst;
        uop_t       uop;
    } id_lane_t;

    typedef id_lane_t [NLANES-1:0] id_bundle_t;

    // register usage of one lane, after format decode
    typedef struct packed {
        reg_idx_t rj;
        reg_idx_t rk;
        logic     rk_used;
        reg_idx_t rd;
        logic     is_load;
    } src_desc_t;

    // execute stage result
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } fwd_bus_t;

    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } wb_port_t;

    // register read to execute
    typedef struct packed {
        logic     valid;
        word_t    pc;
        uop_t     uop;
        reg_idx_t rd;
        word_t    src_a;
        word_t    src_b;
    } ex_slot_t;

    typedef ex_slot_t [NLANES-1:0] ex_bundle_t;

endpackage

//--- hdl/regfile.sv
`include "rr_config.svh"

module regfile import pipe_pkg::*; (
    input  logic             clk,
    input  logic             aresetn,
    input  logic [IDX_W-1:0] raddr [NRPORTS],
    output logic [XLEN-1:0]  rdata [NRPORTS],
    input  wb_port_t         wb    [NWB]
);

    // r0 has no storage
    logic [XLEN-1:0] regs [1:`RR_NREGS-1];

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int r = 1; r < `RR_NREGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // higher port number is written last and wins
            for (int p = 0; p < NWB; p++) begin
                if (wb[p].we && wb[p].rd != '0) begin
                    regs[wb[p].rd] <= wb[p].data;
                end
            end
        end
    end

    // write-through, same priority as the write side
    always_comb begin
        for (int i = 0; i < NRPORTS; i++) begin
            rdata[i] = '0;
            if (raddr[i] != '0) begin
                rdata[i] = regs[raddr[i]];
                for (int p = 0; p < NWB; p++) begin
                    if (wb[p].we && wb[p].rd == raddr[i]) begin
                        rdata[i] = wb[p].data;
                    end
                end
            end
        end
    end

endmodule

//--- hdl/bundle_unpack.sv
module bundle_unpack import isa_pkg::*; import pipe_pkg::*; (
    input  id_bundle_t id_bundle,
    output reg_idx_t   raddr [NRPORTS],
    output src_desc_t  src   [NLANES],
    output imm12_t     imm   [NLANES]
);

    always_comb begin
        for (int i = 0; i < NLANES; i++) begin
            src[i].is_load = id_bundle[i].uop.is_load;
            // rj and rd sit at the same bits in both formats
            src[i].rj      = id_bundle[i].inst.r3.rj;
            src[i].rd      = id_bundle[i].inst.r3.rd;
            if (id_bundle[i].uop.fmt == FMT_3R) begin
                src[i].rk      = id_bundle[i].inst.r3.rk;
                src[i].rk_used = 1'b1;
                imm[i]         = '0;
            end else begin
                // rk field overlaps the immediate here
                src[i].rk      = '0;
                src[i].rk_used = 1'b0;
                imm[i]         = id_bundle[i].inst.ri12.imm12;
            end
            // even ports carry rj, odd ports rk
            raddr[2*i]   = src[i].rj;
            raddr[2*i+1] = src[i].rk;
        end
    end

endmodule

//--- hdl/lane_operand.sv
module lane_operand import isa_pkg::*; import pipe_pkg::*; (
    input  id_lane_t  lane,
    input  src_desc_t src,
    input  imm12_t    imm,
    input  word_t     rj_data,
    input  word_t     rk_data,
    input  fwd_bus_t  fwd [NFWD],
    input  wb_port_t  wb  [NWB],
    output ex_slot_t  slot
);

    word_t opnd_j;
    word_t opnd_k;

    // fwd[1] > fwd[0] > wb[1] > wb[0] > register file
    function automatic word_t resolve(
        input reg_idx_t r,
        input word_t    stored,
        input fwd_bus_t f [NFWD],
        input wb_port_t w [NWB]
    );
        word_t v;
        v = stored;
        // lowest priority first, later matches overwrite
        for (int i = 0; i < NWB; i++) begin
            if (w[i].we && w[i].rd == r) begin
                v = w[i].data;
            end
        end
        for (int i = 0; i < NFWD; i++) begin
            if (f[i].valid && f[i].rd == r) begin
                v = f[i].data;
            end
        end
        if (r == '0) begin
            v = '0;
        end
        return v;
    endfunction

    assign opnd_j = resolve(src.rj, rj_data, fwd, wb);
    assign opnd_k = resolve(src.rk, rk_data, fwd, wb);

    always_comb begin
        slot.valid = lane.valid;
        slot.pc    = lane.pc;
        slot.uop   = lane.uop;
        slot.rd    = src.rd;
        slot.src_a = opnd_j;
        // immediate replaces rk for the 2RI12 format
        slot.src_b = (lane.uop.fmt == FMT_2RI12) ? sext12(imm) : opnd_k;
    end

endmodule

//--- hdl/ex_latch.sv
`include "rr_config.svh"

module ex_latch import pipe_pkg::*; (
    input  logic       clk,
    input  logic       aresetn,
    input  logic       flush,
    input  logic       id_readygo,
    input  logic       ex_allowin,
    input  src_desc_t  src     [NLANES],
    input  ex_slot_t   slot_in [NLANES],
    output logic       reg_allowin,
    output logic       ex_valid,
    output ex_bundle_t ex_bundle
);

    localparam int SHADOW = `RR_LOAD_SHADOW;

    // load destination per lane in the latch, zero for non-loads
    logic [NLANES-1:0][IDX_W-1:0]             ld_rd;
    // index 0 holds the most recent departure
    logic [SHADOW-1:0][NLANES-1:0][IDX_W-1:0] shadow;
    logic [`RR_NREGS-1:0]                     busy;
    logic                                     src_hit;
    logic                                     load_stall;
    logic                                     transfer;
    logic                                     advance;

    assign advance  = ex_valid && ex_allowin;
    assign transfer = id_readygo && reg_allowin;

    // registers whose load result is not yet available
    always_comb begin
        busy = '0;
        for (int l = 0; l < NLANES; l++) begin
            if (ex_valid) begin
                busy[ld_rd[l]] = 1'b1;
            end
            for (int s = 0; s < SHADOW; s++) begin
                busy[shadow[s][l]] = 1'b1;
            end
        end
        busy[0] = 1'b0;
    end

    always_comb begin
        src_hit = 1'b0;
        for (int i = 0; i < NLANES; i++) begin
            if (slot_in[i].valid) begin
                if (busy[src[i].rj]) begin
                    src_hit = 1'b1;
                end
                if (src[i].rk_used && busy[src[i].rk]) begin
                    src_hit = 1'b1;
                end
            end
        end
    end

    assign load_stall  = id_readygo && src_hit;
    assign reg_allowin = (!ex_valid || ex_allowin) && !load_stall && !flush;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            ex_valid <= 1'b0;
            ld_rd    <= '0;
        end else if (flush) begin
            ex_valid <= 1'b0;
        end else if (transfer) begin
            ex_valid <= 1'b1;
            for (int l = 0; l < NLANES; l++) begin
                ld_rd[l] <= (slot_in[l].valid && src[l].is_load) ? src[l].rd : '0;
            end
        end else if (advance) begin
            ex_valid <= 1'b0;
        end
    end

    // payload, held under back-pressure
    always_ff @(posedge clk) begin
        if (transfer) begin
            for (int l = 0; l < NLANES; l++) begin
                ex_bundle[l] <= slot_in[l];
            end
        end
    end

    // flush does not touch the history
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            shadow <= '0;
        end else if (advance) begin
            shadow[0] <= ld_rd;
            for (int s = 1; s < SHADOW; s++) begin
                shadow[s] <= shadow[s-1];
            end
        end
    end

endmodule

//--- hdl/reg_read_stage.sv
module reg_read_stage import pipe_pkg::*; (
    input  logic       clk,
    input  logic       aresetn,
    input  logic       flush,

    // from decode
    input  logic       id_readygo,
    output logic       reg_allowin,
    input  id_bundle_t id_bundle,

    // bypass and writeback
    input  fwd_bus_t   fwd [NFWD],
    input  wb_port_t   wb  [NWB],

    // to execute
    input  logic       ex_allowin,
    output logic       ex_valid,
    output ex_bundle_t ex_bundle
);

    logic [IDX_W-1:0] raddr [NRPORTS];
    logic [XLEN-1:0]  rdata [NRPORTS];
    src_desc_t        src   [NLANES];
    logic [11:0]      imm   [NLANES];
    ex_slot_t         slot  [NLANES];

    bundle_unpack u_unpack (
        .id_bundle (id_bundle),
        .raddr     (raddr),
        .src       (src),
        .imm       (imm)
    );

    regfile u_regfile (
        .clk     (clk),
        .aresetn (aresetn),
        .raddr   (raddr),
        .rdata   (rdata),
        .wb      (wb)
    );

    for (genvar i = 0; i < NLANES; i++) begin : g_lane
        lane_operand u_lane (
            .lane    (id_bundle[i]),
            .src     (src[i]),
            .imm     (imm[i]),
            .rj_data (rdata[2*i]),
            .rk_data (rdata[2*i+1]),
            .fwd     (fwd),
            .wb      (wb),
            .slot    (slot[i])
        );
    end

    ex_latch u_latch (
        .clk         (clk),
        .aresetn     (aresetn),
        .flush       (flush),
        .id_readygo  (id_readygo),
        .ex_allowin  (ex_allowin),
        .src         (src),
        .slot_in     (slot),
        .reg_allowin (reg_allowin),
        .ex_valid    (ex_valid),
        .ex_bundle   (ex_bundle)
    );

endmodule

//--- sim/reg_read_assert.sv
module reg_read_assert import pipe_pkg::*; (
    input logic       clk,
    input logic       aresetn,
    input logic       flush,
    input logic       reg_allowin,
    input logic       ex_allowin,
    input logic       ex_valid,
    input ex_bundle_t ex_bundle
);

    int fail_cnt = 0;

    // payload frozen while execute refuses it
    a_hold: assert property (@(posedge clk) disable iff (!aresetn)
        ex_valid && !ex_allowin |=> $stable(ex_bundle))
        else begin
            $error("ex_bundle changed while ex_allowin was low");
            fail_cnt++;
        end

    a_blocked: assert property (@(posedge clk) disable iff (!aresetn)
        ex_valid && !ex_allowin |-> !reg_allowin)
        else begin
            $error("reg_allowin high under back-pressure");
            fail_cnt++;
        end

    a_flush: assert property (@(posedge clk) disable iff (!aresetn)
        flush |=> !ex_valid)
        else begin
            $error("ex_valid still high after flush");
            fail_cnt++;
        end

endmodule

bind reg_read_stage reg_read_assert u_chk (.*);

//--- sim/tb_reg_read.sv
`include "rr_config.svh"

module tb_reg_read import isa_pkg::*; import pipe_pkg::*; ();

    localparam int NCYCLES = 3000;
    localparam int TIMEOUT = (NCYCLES + 16 + 20) * 10 + 2000;
    localparam int SHADOW  = `RR_LOAD_SHADOW;

    logic       clk;
    logic       aresetn;
    logic       flush;
    logic       id_readygo;
    logic       reg_allowin;
    id_bundle_t id_bundle;
    fwd_bus_t   fwd [NFWD];
    wb_port_t   wb  [NWB];
    logic       ex_allowin;
    logic       ex_valid;
    ex_bundle_t ex_bundle;

    // reference state: registers, output latch, load history
    word_t    ref_regs [`RR_NREGS];
    ex_slot_t m_slot   [NLANES];
    reg_idx_t m_ld_rd  [NLANES];
    reg_idx_t m_shadow [SHADOW][NLANES];
    logic     m_valid;
    int       errors;
    int       checks;
    int       transfers;

    reg_read_stage dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t sign_ext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // first match wins, r0 is always zero
    function automatic word_t operand(input reg_idx_t r);
        word_t v;
        if (r == 0)
            v = '0;
        else if (fwd[1].valid && fwd[1].rd == r)
            v = fwd[1].data;
        else if (fwd[0].valid && fwd[0].rd == r)
            v = fwd[0].data;
        else if (wb[1].we && wb[1].rd == r)
            v = wb[1].data;
        else if (wb[0].we && wb[0].rd == r)
            v = wb[0].data;
        else
            v = ref_regs[r];
        return v;
    endfunction

    function automatic logic is_busy(input reg_idx_t r);
        logic b;
        b = 1'b0;
        for (int l = 0; l < NLANES; l++) begin
            if (m_valid && m_ld_rd[l] == r)
                b = 1'b1;
            for (int s = 0; s < SHADOW; s++) begin
                if (m_shadow[s][l] == r)
                    b = 1'b1;
            end
        end
        return b && r != 0;
    endfunction

    function automatic logic stall_expected();
        logic  st;
        word_t w;
        st = 1'b0;
        for (int l = 0; l < NLANES; l++) begin
            w = id_bundle[l].inst;
            if (id_readygo && id_bundle[l].valid) begin
                if (is_busy(w[9:5]))
                    st = 1'b1;
                if (id_bundle[l].uop.fmt == FMT_3R && is_busy(w[14:10]))
                    st = 1'b1;
            end
        end
        return st;
    endfunction

    // field positions: rd 4..0, rj 9..5, rk 14..10, imm12 21..10
    function automatic ex_slot_t expected_slot(input int l);
        ex_slot_t s;
        word_t    w;
        w       = id_bundle[l].inst;
        s.valid = id_bundle[l].valid;
        s.pc    = id_bundle[l].pc;
        s.uop   = id_bundle[l].uop;
        s.rd    = w[4:0];
        s.src_a = operand(w[9:5]);
        if (id_bundle[l].uop.fmt == FMT_2RI12)
            s.src_b = sign_ext12(w[21:10]);
        else
            s.src_b = operand(w[14:10]);
        return s;
    endfunction

    task automatic compare_field(input string name, input int l, input word_t got,
                                 input word_t exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("Error: ex_bundle[%0d].%s = %h, expected %h", l, name, got, exp);
        end
    endtask

    task automatic check_cycle();
        logic exp_allowin;
        logic stall;
        logic xfer;
        logic adv;
        stall       = stall_expected();
        exp_allowin = (!m_valid || ex_allowin) && !stall && !flush;
        checks += 3;
        assert (reg_allowin === exp_allowin)
        else begin
            errors++;
            $display("Error: reg_allowin = %h, expected %h", reg_allowin, exp_allowin);
        end
        assert (!(stall && reg_allowin))
        else begin
            errors++;
            $display("bundle accepted while a load-use hazard was pending");
        end
        assert (ex_valid === m_valid)
        else begin
            errors++;
            $display("Error: ex_valid = %h, expected %h", ex_valid, m_valid);
        end
        for (int l = 0; l < NLANES && m_valid; l++) begin
            compare_field("valid", l, ex_bundle[l].valid, m_slot[l].valid);
            if (m_slot[l].valid) begin
                compare_field("pc", l, ex_bundle[l].pc, m_slot[l].pc);
                compare_field("uop", l, ex_bundle[l].uop, m_slot[l].uop);
                compare_field("rd", l, ex_bundle[l].rd, m_slot[l].rd);
                compare_field("src_a", l, ex_bundle[l].src_a, m_slot[l].src_a);
                compare_field("src_b", l, ex_bundle[l].src_b, m_slot[l].src_b);
            end
        end
        // effect of the coming edge
        xfer = id_readygo && exp_allowin;
        adv  = m_valid && ex_allowin;
        for (int l = 0; l < NLANES && adv; l++) begin
            for (int s = SHADOW - 1; s > 0; s--)
                m_shadow[s][l] = m_shadow[s-1][l];
            m_shadow[0][l] = m_ld_rd[l];
        end
        if (flush) begin
            m_valid = 1'b0;
        end else if (xfer) begin
            m_valid = 1'b1;
            transfers++;
            for (int l = 0; l < NLANES; l++) begin
                m_slot[l]  = expected_slot(l);
                m_ld_rd[l] = (m_slot[l].valid && m_slot[l].uop.is_load) ? m_slot[l].rd : '0;
            end
        end else if (adv) begin
            m_valid = 1'b0;
        end
        for (int p = 0; p < NWB; p++) begin
            if (wb[p].we && wb[p].rd != 0)
                ref_regs[wb[p].rd] = wb[p].data;
        end
    endtask

    task automatic idle_inputs();
        flush      <= 1'b0;
        id_readygo <= 1'b0;
        ex_allowin <= 1'b1;
        id_bundle  <= '0;
        for (int i = 0; i < NFWD; i++) begin
            fwd[i] <= '0;
            wb[i]  <= '0;
        end
    endtask

    // indices limited to r0..r7 so that hazards are frequent
    task automatic drive_random();
        id_lane_t lane;
        word_t    w;
        fwd_bus_t f;
        wb_port_t p;
        for (int l = 0; l < NLANES; l++) begin
            w                = $urandom;
            w[4:0]           = $urandom_range(7, 0);
            w[9:5]           = $urandom_range(7, 0);
            lane.valid       = $urandom_range(99, 0) < 85;
            lane.pc          = $urandom;
            lane.uop.fmt     = inst_fmt_e'($urandom_range(1, 0));
            lane.uop.is_load = $urandom_range(3, 0) == 0;
            lane.uop.alu_op  = $urandom_range(15, 0);
            if (lane.uop.fmt == FMT_3R)
                w[14:10] = $urandom_range(7, 0);
            lane.inst     = w;
            id_bundle[l] <= lane;
        end
        for (int i = 0; i < NFWD; i++) begin
            f.valid = $urandom_range(9, 0) < 4;
            f.rd    = $urandom_range(7, 0);
            f.data  = $urandom;
            p.we    = $urandom_range(1, 0);
            p.rd    = $urandom_range(7, 0);
            p.data  = $urandom;
            fwd[i] <= f;
            wb[i]  <= p;
        end
        id_readygo <= $urandom_range(3, 0) != 0;
        ex_allowin <= $urandom_range(9, 0) < 7;
        flush      <= $urandom_range(49, 0) == 0;
    endtask

    always @(negedge clk) begin
        if (aresetn)
            check_cycle();
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before the stimulus sequence completed");
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(83));
        errors    = 0;
        checks    = 0;
        transfers = 0;
        m_valid   = 1'b0;
        for (int r = 0; r < `RR_NREGS; r++)
            ref_regs[r] = '0;
        for (int l = 0; l < NLANES; l++) begin
            m_ld_rd[l] = '0;
            for (int s = 0; s < SHADOW; s++)
                m_shadow[s][l] = '0;
        end
        aresetn = 1'b0;
        idle_inputs();
        repeat (16) @(posedge clk);
        aresetn <= 1'b1;
        @(negedge clk);
        checks++;
        assert (!ex_valid && reg_allowin)
        else begin
            errors++;
            $display("Error: after reset ex_valid = %h, reg_allowin = %h, expected 0 and 1",
                     ex_valid, reg_allowin);
        end
        repeat (NCYCLES) begin
            @(posedge clk);
            drive_random();
        end
        @(posedge clk);
        idle_inputs();
        repeat (4) @(posedge clk);
        $display("checks %0d, errors %0d, assertion failures %0d, transfers %0d",
                 checks, errors, dut0.u_chk.fail_cnt, transfers);
        if (errors == 0 && dut0.u_chk.fail_cnt == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/regfile.sv
hdl/bundle_unpack.sv
hdl/lane_operand.sv
hdl/ex_latch.sv
hdl/reg_read_stage.sv
sim/reg_read_assert.sv
sim/tb_reg_read.sv
